//--- build.f
+incdir+design
design/dot_pkg.sv
design/a_line_fifo.sv
design/dot_sequencer.sv
design/bit_plane_tree.sv
design/bank_accumulator.sv
design/dot_product_engine.sv
sim/tb_dot_product_engine.sv

//--- design/a_line_fifo.sv
// a-line buffer, register array, one credit back per pop
// producer holds FIFO_DEPTH credits so no full flag goes out
`include "dot_consts.svh"

module a_line_fifo
    import dot_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_en,
    input  a_line_t wr_data,
    input  logic    rd_en,
    output a_line_t rd_data,     // valid the cycle after rd_en
    output logic    empty,
    output logic    credit
);

    localparam int             PTR_W     = $clog2(`FIFO_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = `FIFO_DEPTH;

    a_line_t          mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;      // one extra bit to tell full from empty
    logic             full;

    // count moves on the pop edge, so a pop issued now is already seen next cycle
    assign empty  = (count == '0);
    assign full   = (count == DEPTH_CNT);
    assign credit = rd_en;        // same cycle as the pop

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_ptr];   // registered read
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;      // wraps, depth is a power of two
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    // producer side keeps its credit count right
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("a-line write while buffer full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
        else $error("a-line pop while buffer empty");

endmodule

//--- design/bank_accumulator.sv
// per-bank weighting by plane position and dot-product accumulation
// plane k weighs 2^-(k+1), MSB plane first
// shift and add happen in the same cycle as the tree output
`include "dot_consts.svh"

module bank_accumulator
    import dot_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  x_word_t    sum,
    input  plane_tag_t tag,
    output dot_t       result,
    output logic       result_valid
);

    acc_t                         sum_ext;
    acc_t                         weighted;
    acc_t                         acc_q;
    acc_t                         acc_next;
    logic [$bits(plane_idx_t):0]  shift_amt;   // 1..MAX_PLANES

    // guard bits below the lsb keep some of the shifted-out fraction
    assign sum_ext   = {sum, {`GUARD_BITS{1'b0}}};
    assign shift_amt = {1'b0, tag.plane} + 1'b1;
    assign weighted  = sum_ext >>> shift_amt;        // arithmetic, keeps sign
    assign acc_next  = tag.first ? weighted : acc_q + weighted;

    always_ff @(posedge clk)
    begin
        if (tag.valid)
            acc_q <= acc_next;
        if (tag.valid && tag.last)
            result <= acc_next[`ACC_WIDTH-1:`GUARD_BITS];   // floor, guard bits dropped
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            result_valid <= 1'b0;
        else
            result_valid <= tag.valid && tag.last;   // one pulse per sample
    end

endmodule

//--- design/bit_plane_tree.sv
// one bank: mask x features by plane bits, pipelined adder tree
// latency TREE_DEPTH+1 cycles, a new line every cycle
// 32-bit sums wrap, x range must keep them in bounds
`include "dot_consts.svh"

module bit_plane_tree
    import dot_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`BITS_PER_BANK-1:0] plane_bits,
    input  x_line_t                   x_line,
    input  plane_tag_t                tag_in,
    output x_word_t                   sum,
    output plane_tag_t                tag_out
);

    localparam int LEAVES = `BITS_PER_BANK;
    localparam int NODES  = 2 * LEAVES - 1;

    // heap order, node k sums nodes 2k+1 and 2k+2, leaves at the tail
    x_word_t    node [NODES];
    plane_tag_t tag_pipe [`TREE_DEPTH + 1];   // one per register level

    for (genvar j = 0; j < LEAVES; j++)
    begin : g_leaf
        always_ff @(posedge clk)
        begin
            if (plane_bits[j])
                node[LEAVES - 1 + j] <= x_word_t'(x_line[j*`X_WIDTH +: `X_WIDTH]);
            else
                node[LEAVES - 1 + j] <= '0;   // bit clear, feature drops out
        end
    end

    for (genvar k = 0; k < LEAVES - 1; k++)
    begin : g_node
        always_ff @(posedge clk)
        begin
            node[k] <= node[2*k + 1] + node[2*k + 2];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int d = 0; d <= `TREE_DEPTH; d++)
                tag_pipe[d] <= '0;
        end
        else
        begin
            tag_pipe[0] <= tag_in;                  // beside the leaves
            for (int d = 1; d <= `TREE_DEPTH; d++)
                tag_pipe[d] <= tag_pipe[d-1];
        end
    end

    assign sum     = node[0];                       // root
    assign tag_out = tag_pipe[`TREE_DEPTH];

endmodule

//--- design/dot_consts.svh
// sizing constants for the bit-serial dot-product engine
// BITS_PER_BANK must be 2**TREE_DEPTH and FIFO_DEPTH a power of two
// ACC_WIDTH is X_WIDTH plus GUARD_BITS
`ifndef DOT_CONSTS_SVH
`define DOT_CONSTS_SVH

`define NUM_BANKS      4    // banks, one sample each per group
`define BITS_PER_BANK  8    // features per chunk
`define TREE_DEPTH     3    // log2 of BITS_PER_BANK
`define X_WIDTH        32   // one x feature
`define GUARD_BITS     4    // fraction bits below the result
`define ACC_WIDTH      36
`define MAX_PLANES     8    // most bit planes per sample
`define FIFO_DEPTH     16   // a-line buffer depth, also producer credits
`define CHUNK_WIDTH    8
`define GROUP_WIDTH    16

`endif

//--- design/dot_pkg.sv
// shared types of the dot-product engine
// a_line_t bank i owns bits i*BITS_PER_BANK and up
`include "dot_consts.svh"

package dot_pkg;

    typedef logic [`NUM_BANKS*`BITS_PER_BANK-1:0]  a_line_t;   // one bit plane, all banks
    typedef logic signed [`X_WIDTH-1:0]            x_word_t;
    typedef logic [`BITS_PER_BANK*`X_WIDTH-1:0]    x_line_t;   // feature j at j*X_WIDTH
    typedef logic signed [`ACC_WIDTH-1:0]          acc_t;
    typedef logic signed [`ACC_WIDTH-`GUARD_BITS-1:0] dot_t;   // acc with guard bits dropped
    typedef logic [$clog2(`MAX_PLANES)-1:0]        plane_idx_t;
    typedef logic [`CHUNK_WIDTH-1:0]               chunk_cnt_t;
    typedef logic [`GROUP_WIDTH-1:0]               group_cnt_t;

    // travels beside the data through tree and accumulator
    typedef struct packed {
        logic       valid;
        plane_idx_t plane;    // 0 is the MSB plane
        logic       first;    // chunk 0 plane 0
        logic       last;     // final chunk, final plane
    } plane_tag_t;

    // run setup, sampled on start
    typedef struct packed {
        group_cnt_t                    num_groups;
        chunk_cnt_t                    num_chunks;   // at least 1
        logic [$clog2(`MAX_PLANES):0]  num_planes;   // 1..MAX_PLANES
    } run_cfg_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_GROUP,
        SEQ_STREAM,
        SEQ_DONE
    } seq_state_t;

endpackage

//--- design/dot_product_engine.sv
// bit-serial dot-product engine top, NUM_BANKS samples per group
// x memory external with fixed one-cycle read latency
// last pop of a group to result_valid is 6 cycles, done likewise
`include "dot_consts.svh"

module dot_product_engine
    import dot_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  run_cfg_t              cfg,
    input  logic                  a_valid,
    input  a_line_t               a_data,
    output logic                  a_credit,
    output logic                  x_rd_en,
    output chunk_cnt_t            x_rd_addr,
    input  x_line_t               x_rd_data,
    output logic                  result_valid,
    output dot_t [`NUM_BANKS-1:0] result,
    output logic                  done
);

    // busy fall to done, covers tree plus accumulator
    localparam int DRAIN_LEN = `TREE_DEPTH + 1;

    a_line_t                fifo_data;
    logic                   fifo_empty;
    logic                   pop;
    plane_tag_t             seq_tag;
    logic                   busy;
    logic                   busy_q;
    logic [DRAIN_LEN-1:0]   drain;
    x_word_t                bank_sum [`NUM_BANKS];
    plane_tag_t             bank_tag [`NUM_BANKS];
    logic [`NUM_BANKS-1:0]  bank_valid;

    a_line_fifo i_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (a_valid),
        .wr_data (a_data),
        .rd_en   (pop),
        .rd_data (fifo_data),
        .empty   (fifo_empty),
        .credit  (a_credit)
    );

    dot_sequencer i_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .x_rd_en    (x_rd_en),
        .x_rd_addr  (x_rd_addr),
        .tag        (seq_tag),
        .busy       (busy)
    );

    for (genvar i = 0; i < `NUM_BANKS; i++)
    begin : g_bank
        bit_plane_tree i_tree (
            .clk        (clk),
            .rst_n      (rst_n),
            .plane_bits (fifo_data[i*`BITS_PER_BANK +: `BITS_PER_BANK]),
            .x_line     (x_rd_data),              // same x line for every bank
            .tag_in     (seq_tag),
            .sum        (bank_sum[i]),
            .tag_out    (bank_tag[i])
        );

        bank_accumulator i_acc (
            .clk          (clk),
            .rst_n        (rst_n),
            .sum          (bank_sum[i]),
            .tag          (bank_tag[i]),
            .result       (result[i]),
            .result_valid (bank_valid[i])
        );
    end

    assign result_valid = bank_valid[0];   // banks run in lockstep

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q <= 1'b0;
            drain  <= '0;
            done   <= 1'b0;
        end
        else
        begin
            busy_q <= busy;
            drain  <= {drain[DRAIN_LEN-2:0], busy_q & ~busy};   // run just ended
            if (drain[DRAIN_LEN-1])
                done <= 1'b1;                                   // last result out now
            else if (start && !busy)
                done <= 1'b0;
        end
    end

    // drain chain and tree pipeline must agree, no bank result once done is up
    a_no_result_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        (|bank_valid) |-> !$past(done))
        else $error("bank result_valid after done");

endmodule

//--- design/dot_sequencer.sv
// walks groups, chunks and bit planes, one pop and one x read per cycle
// cfg is taken on start only when idle; num_chunks and num_planes nonzero
// tag is registered to line up with buffer and x memory data
`include "dot_consts.svh"

module dot_sequencer
    import dot_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  run_cfg_t   cfg,
    input  logic       fifo_empty,
    output logic       pop,
    output logic       x_rd_en,
    output chunk_cnt_t x_rd_addr,
    output plane_tag_t tag,
    output logic       busy
);

    seq_state_t state;
    run_cfg_t   cfg_q;
    group_cnt_t group;
    chunk_cnt_t chunk;
    plane_idx_t plane;
    logic       last_plane;
    logic       last_chunk;
    logic       last_group;

    assign last_plane = ({1'b0, plane} == cfg_q.num_planes - 1'b1);
    assign last_chunk = (chunk == cfg_q.num_chunks - 1'b1);
    assign last_group = (group == cfg_q.num_groups - 1'b1);

    // stall whenever the buffer runs dry
    assign pop       = (state == SEQ_STREAM) && !fifo_empty;
    assign x_rd_en   = pop;              // x line re-read every plane
    assign x_rd_addr = chunk;
    assign busy      = (state == SEQ_GROUP) || (state == SEQ_STREAM);

    always_ff @(posedge clk)
    begin
        if (start && state == SEQ_IDLE)
            cfg_q <= cfg;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= SEQ_IDLE;
            group <= '0;
            chunk <= '0;
            plane <= '0;
            tag   <= '0;
        end
        else
        begin
            // tag of this cycle's pop, seen next cycle with the data
            tag.valid <= pop;
            tag.plane <= plane;
            tag.first <= (chunk == '0) && (plane == '0);
            tag.last  <= last_chunk && last_plane;

            case (state)
                SEQ_IDLE:
                begin
                    if (start)
                        state <= SEQ_GROUP;
                end
                SEQ_GROUP:
                begin
                    group <= '0;
                    chunk <= '0;
                    plane <= '0;
                    state <= (cfg_q.num_groups == '0) ? SEQ_DONE : SEQ_STREAM;
                end
                SEQ_STREAM:
                begin
                    if (pop)
                    begin
                        if (!last_plane)
                            plane <= plane + 1'b1;
                        else
                        begin
                            plane <= '0;
                            if (!last_chunk)
                                chunk <= chunk + 1'b1;
                            else
                            begin
                                chunk <= '0;
                                if (last_group)
                                    state <= SEQ_DONE;
                                else
                                    group <= group + 1'b1;   // next group, no bubble
                            end
                        end
                    end
                end
                SEQ_DONE:
                    state <= SEQ_IDLE;
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

    // counters stay inside the configured walk
    a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SEQ_STREAM) |->
            (({1'b0, plane} < cfg_q.num_planes) && (chunk < cfg_q.num_chunks)))
        else $error("plane or chunk counter outside configured range");

    // zero chunks or planes would never end a group
    a_cfg_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (start && state == SEQ_IDLE) |->
            ((cfg.num_chunks != '0) && (cfg.num_planes != '0)
             && (cfg.num_planes <= `MAX_PLANES)))
        else $error("start with illegal chunk or plane count");

endmodule

//--- sim/tb_dot_product_engine.sv
// testbench for the dot-product engine, random lines and x from a fixed seed
// producer keeps FIFO_DEPTH credits, x memory answers one cycle after x_rd_en
// expected results come from a per-line model of the plane weighting
`include "dot_consts.svh"

module tb_dot_product_engine
    import dot_pkg::*;
();

    typedef dot_t [`NUM_BANKS-1:0] result_vec_t;

    // lines of all runs, used for the cycle limit
    localparam int TOTAL_LINES    = 1*2*8 + 1*2*1 + 1*2*3 + 1*2*8 + 5*3*8;
    localparam int TIMEOUT_CYCLES = TOTAL_LINES * 4 + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    run_cfg_t              cfg;
    logic                  a_valid;
    a_line_t               a_data;
    logic                  a_credit;
    logic                  x_rd_en;
    chunk_cnt_t            x_rd_addr;
    x_line_t               x_rd_data;
    logic                  result_valid;
    dot_t [`NUM_BANKS-1:0] result;
    logic                  done;

    integer      seed;
    x_line_t     x_mem [256];
    a_line_t     line_q [$];          // lines still to send
    result_vec_t exp_q [$];           // expected results, group order
    string       test_name;
    int          credits = `FIFO_DEPTH;
    int          lines_sent = 0;
    int          credit_pulses = 0;
    int          run_groups = 0;
    int          results_run = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_cnt = 0;
    logic        x_pend = 1'b0;       // read issued last cycle
    chunk_cnt_t  x_pend_addr;
    logic        done_prev = 1'b0;

    dot_product_engine i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .cfg          (cfg),
        .a_valid      (a_valid),
        .a_data       (a_data),
        .a_credit     (a_credit),
        .x_rd_en      (x_rd_en),
        .x_rd_addr    (x_rd_addr),
        .x_rd_data    (x_rd_data),
        .result_valid (result_valid),
        .result       (result),
        .done         (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // sum of the x features whose plane bit is set
    function automatic acc_t plane_sum(input logic [`BITS_PER_BANK-1:0] bits, input x_line_t xl);
        acc_t s;
        s = '0;
        for (int j = 0; j < `BITS_PER_BANK; j++)
            if (bits[j])
                s = s + acc_t'(x_word_t'(xl[j*`X_WIDTH +: `X_WIDTH]));
        return s;
    endfunction

    // plane k counts 2^-(k+1), kept with guard bits
    function automatic acc_t plane_weight(input acc_t s, input int k);
        acc_t w;
        w = s <<< `GUARD_BITS;
        return w >>> (k + 1);
    endfunction

    task automatic build_run(input int groups, input int chunks, input int planes);
        acc_t        acc [`NUM_BANKS];
        a_line_t     line;
        result_vec_t exp_vec;
        for (int g = 0; g < groups; g++)
        begin
            for (int i = 0; i < `NUM_BANKS; i++)
                acc[i] = '0;
            for (int c = 0; c < chunks; c++)
                for (int p = 0; p < planes; p++)
                begin
                    line = $random(seed);
                    line_q.push_back(line);
                    for (int i = 0; i < `NUM_BANKS; i++)
                        acc[i] = acc[i] + plane_weight(
                            plane_sum(line[i*`BITS_PER_BANK +: `BITS_PER_BANK], x_mem[c]), p);
                end
            for (int i = 0; i < `NUM_BANKS; i++)
                exp_vec[i] = dot_t'(acc[i] >>> `GUARD_BITS);   // floor, guard bits off
            exp_q.push_back(exp_vec);
        end
    endtask

    task automatic run_case(input string name, input int groups, input int chunks,
                            input int planes);
        @(posedge clk);                 // build off the drive slot, keeps seed order fixed
        test_name   = name;
        run_groups  = groups;
        results_run = 0;
        build_run(groups, chunks, planes);
        #5;
        cfg.num_groups = group_cnt_t'(groups);
        cfg.num_chunks = chunk_cnt_t'(chunks);
        cfg.num_planes = planes[$bits(cfg.num_planes)-1:0];
        start = 1'b1;
        @(posedge clk);
        #5;
        start = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #5;
        end
        repeat (10) @(posedge clk);    // quiet window, no result after done
    endtask

    task automatic report_and_finish;
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // per-cycle drive and monitor, 5 units after the edge
    initial
    begin
        forever
        begin
            @(posedge clk);
            #5;
            if (rst_n)
            begin
                x_rd_data   = x_pend ? x_mem[x_pend_addr] : '0;   // answer last cycle's read
                x_pend      = x_rd_en;
                x_pend_addr = x_rd_addr;
                a_valid     = 1'b0;
                if (credits > 0 && line_q.size() > 0 && ($random(seed) & 3) != 0)
                begin
                    a_valid = 1'b1;                    // gap on one draw in four
                    a_data  = line_q.pop_front();
                    credits--;
                    lines_sent++;
                end
                if (a_credit)
                begin
                    credits++;                         // usable from next cycle on
                    credit_pulses++;
                end
                assert (credits >= 0 && credits <= `FIFO_DEPTH)
                else
                begin
                    $display("producer credit count out of range: %0d", credits);
                    other_errors++;
                end
                if (result_valid)
                begin
                    assert (exp_q.size() > 0 && !done_prev)
                    else
                    begin
                        $display("result_valid with no result outstanding in %s", test_name);
                        other_errors++;
                    end
                    if (exp_q.size() > 0)
                    begin
                        for (int i = 0; i < `NUM_BANKS; i++)
                            assert (result[i] == exp_q[0][i])
                            else
                            begin
                                $display("FAILED %s expected %0d actual %0d",
                                         test_name, exp_q[0][i], result[i]);
                                value_errors++;
                            end
                        void'(exp_q.pop_front());
                        results_run++;
                    end
                end
                if (done && !done_prev)
                begin
                    assert (results_run == run_groups)
                    else
                    begin
                        $display("FAILED done_count expected %0d actual %0d",
                                 run_groups, results_run);
                        value_errors++;
                    end
                    assert (credit_pulses == lines_sent)
                    else
                    begin
                        $display("FAILED credit_accounting expected %0d actual %0d",
                                 lines_sent, credit_pulses);
                        value_errors++;
                    end
                end
                done_prev = done;
            end
        end
    end

    initial
    begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, engine never finished", cycle_cnt);
        other_errors++;
        report_and_finish();
    end

    initial
    begin
        seed      = 32'haa0f_9fc9;
        rst_n     = 1'b0;
        start     = 1'b0;
        cfg       = '0;
        a_valid   = 1'b0;
        a_data    = '0;
        x_rd_data = '0;
        for (int a = 0; a < 256; a++)
            for (int j = 0; j < `BITS_PER_BANK; j++)
                x_mem[a][j*`X_WIDTH +: `X_WIDTH] = $random(seed) % 32768;   // within +-2^15
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;
        test_name = "reset_idle";
        repeat (10)
        begin
            @(posedge clk);
            #5;
            assert (!a_credit && !x_rd_en && !result_valid && !done)
            else
            begin
                $display("outputs active after reset with no start");
                other_errors++;
            end
        end
        run_case("single_group", 1, 2, 8);
        run_case("plane_count", 1, 2, 1);
        run_case("plane_count", 1, 2, 3);
        run_case("plane_count", 1, 2, 8);
        run_case("stalled_multi_group", 5, 3, 8);
        report_and_finish();
    end

endmodule
